// ==== common/aes_pkg.sv ====
package aes_pkg;

  // One AES state or key, byte 0 in the top byte as in FIPS-197
  typedef logic [127:0] aes_block_t;

  // Job controller states
  typedef enum logic [2:0] {
    AES_IDLE,
    AES_STARTING,
    AES_LOADING,
    AES_WORKING,
    AES_STORING,
    AES_FINISHED
  } aes_state_t;

  // Host register word offsets
  typedef enum logic [2:0] {
    REG_TRIGGER = 3'd0,
    REG_STATUS  = 3'd1,
    REG_SRC     = 3'd2,
    REG_DST     = 3'd3,
    REG_KEY0    = 3'd4,
    REG_KEY1    = 3'd5,
    REG_KEY2    = 3'd6,
    REG_KEY3    = 3'd7
  } aes_reg_t;

  typedef struct packed {
    logic load_start;
    logic store_start;
    logic capture;
  } ctrl_streamer_t;

  typedef struct packed {
    logic src_ready;
    logic sink_ready;
    logic load_done;
    logic store_done;
  } flags_streamer_t;

  typedef struct packed {
    logic clear;
    logic start;
    logic enable;
  } ctrl_engine_t;

  typedef struct packed {
    logic done;
  } flags_engine_t;

  typedef struct packed {
    logic done;
  } ctrl_slave_t;

  typedef struct packed {
    logic start;
  } flags_slave_t;

  // Job parameters as programmed by the host
  typedef struct packed {
    logic [31:0] src_addr;
    logic [31:0] dst_addr;
    aes_block_t  key;
  } ctrl_regfile_t;

endpackage

// ==== common/aes_mem_if.sv ====
`timescale 1ns/1ps

// Word-wide memory port, one-cycle read latency and no stall
interface aes_mem_if #(
  parameter int ADDR_WIDTH = 16
) ();

  logic                  req;
  logic                  we;
  logic [ADDR_WIDTH-1:0] addr;
  logic [31:0]           wdata;
  logic [31:0]           rdata;

  modport streamer (
    output req,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  modport top (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

// ==== aes_engine/aes_sbox.sv ====
`timescale 1ns/1ps

module aes_sbox (
  input  logic [7:0] in_i,
  output logic [7:0] out_o
);

  // Forward S-box, entry 0 first
  localparam logic [0:255][7:0] SBOX = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  assign out_o = SBOX[in_i];

endmodule

// ==== aes_engine/aes_engine.sv ====
`timescale 1ns/1ps

module aes_engine import aes_pkg::*; (
  input  logic          clk,
  input  logic          reset_n,
  input  ctrl_engine_t  ctrl_engine_i,
  output flags_engine_t flags_engine_o,
  input  aes_block_t    key_i,
  input  aes_block_t    plaintext_i,
  output aes_block_t    ciphertext_o
);

  aes_block_t  state_q;
  aes_block_t  rkey_q;
  aes_block_t  next_rkey;
  aes_block_t  round_out;
  logic [3:0]  round_q;
  logic        busy_q;
  logic        done_q;
  logic        advance;
  logic [7:0]  rcon;
  logic [7:0]  sub_bytes [16];
  logic [31:0] rot_word;
  logic [31:0] sub_word;
  logic [31:0] nk0;
  logic [31:0] nk1;
  logic [31:0] nk2;
  logic [31:0] nk3;

  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic logic [31:0] mix_column(input logic [31:0] col);
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  assign advance = ctrl_engine_i.enable && busy_q;

  // Round constant for the key being derived in this round
  always_comb begin
    case (round_q)
      4'd1:    rcon = 8'h01;
      4'd2:    rcon = 8'h02;
      4'd3:    rcon = 8'h04;
      4'd4:    rcon = 8'h08;
      4'd5:    rcon = 8'h10;
      4'd6:    rcon = 8'h20;
      4'd7:    rcon = 8'h40;
      4'd8:    rcon = 8'h80;
      4'd9:    rcon = 8'h1b;
      4'd10:   rcon = 8'h36;
      default: rcon = 8'h00;
    endcase
  end

  for (genvar i = 0; i < 16; i++) begin : gen_sub_bytes
    aes_sbox sbox_inst (
      .in_i  (state_q[127-8*i -: 8]),
      .out_o (sub_bytes[i])
    );
  end

  // Key schedule works on RotWord of the last column
  assign rot_word = {rkey_q[23:0], rkey_q[31:24]};

  for (genvar j = 0; j < 4; j++) begin : gen_sub_word
    aes_sbox sbox_inst (
      .in_i  (rot_word[31-8*j -: 8]),
      .out_o (sub_word[31-8*j -: 8])
    );
  end

  assign nk0       = rkey_q[127:96] ^ sub_word ^ {rcon, 24'h0};
  assign nk1       = rkey_q[95:64] ^ nk0;
  assign nk2       = rkey_q[63:32] ^ nk1;
  assign nk3       = rkey_q[31:0] ^ nk2;
  assign next_rkey = {nk0, nk1, nk2, nk3};

  always_comb begin : round_logic
    aes_block_t shifted;
    aes_block_t mixed;
    // ShiftRows on the substituted bytes, byte r of column c
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted[127-8*(4*c+r) -: 8] = sub_bytes[4*((c+r)%4)+r];
      end
    end
    for (int c = 0; c < 4; c++) begin
      mixed[127-32*c -: 32] = mix_column(shifted[127-32*c -: 32]);
    end
    // Last round has no MixColumns
    round_out = (round_q == 4'd10) ? (shifted ^ next_rkey) : (mixed ^ next_rkey);
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      round_q <= '0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
    end else if (ctrl_engine_i.clear) begin
      round_q <= '0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (ctrl_engine_i.start) begin
        round_q <= 4'd1;
        busy_q  <= 1'b1;
      end else if (advance) begin
        round_q <= round_q + 4'd1;
        if (round_q == 4'd10) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Initial AddRoundKey on start, then one full round per cycle
  always_ff @(posedge clk) begin
    if (ctrl_engine_i.start) begin
      state_q <= plaintext_i ^ key_i;
      rkey_q  <= key_i;
    end else if (advance) begin
      state_q <= round_out;
      rkey_q  <= next_rkey;
    end
  end

  assign flags_engine_o.done = done_q;
  assign ciphertext_o        = state_q;

endmodule

// ==== hw/aes_regfile.sv ====
`timescale 1ns/1ps

module aes_regfile import aes_pkg::*; (
  input  logic          clk,
  input  logic          reset_n,
  input  logic          cfg_we_i,
  input  logic [2:0]    cfg_addr_i,
  input  logic [31:0]   cfg_wdata_i,
  output logic [31:0]   cfg_rdata_o,
  input  ctrl_slave_t   slave_ctrl_i,
  output flags_slave_t  slave_flags_o,
  output ctrl_regfile_t reg_file_o
);

  aes_reg_t    reg_sel;
  logic        trigger;
  logic        busy_q;
  logic        start_q;
  logic [31:0] src_q;
  logic [31:0] dst_q;
  logic [31:0] key_q [4];

  assign reg_sel = aes_reg_t'(cfg_addr_i);

  // A trigger only counts while no job is running
  assign trigger = cfg_we_i && (reg_sel == REG_TRIGGER) && !busy_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_q  <= 1'b0;
      start_q <= 1'b0;
    end else begin
      start_q <= trigger;
      if (trigger) begin
        busy_q <= 1'b1;
      end else if (slave_ctrl_i.done) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cfg_we_i) begin
      case (reg_sel)
        REG_SRC: src_q <= cfg_wdata_i;
        REG_DST: dst_q <= cfg_wdata_i;
        REG_KEY0, REG_KEY1, REG_KEY2, REG_KEY3: key_q[cfg_addr_i[1:0]] <= cfg_wdata_i;
        default: ;
      endcase
    end
  end

  // Host read path, purely combinational
  always_comb begin
    case (reg_sel)
      REG_TRIGGER: cfg_rdata_o = '0;
      REG_STATUS:  cfg_rdata_o = {31'b0, busy_q};
      REG_SRC:     cfg_rdata_o = src_q;
      REG_DST:     cfg_rdata_o = dst_q;
      REG_KEY0, REG_KEY1, REG_KEY2, REG_KEY3: cfg_rdata_o = key_q[cfg_addr_i[1:0]];
      default:     cfg_rdata_o = '0;
    endcase
  end

  assign slave_flags_o.start = start_q;

  assign reg_file_o.src_addr = src_q;
  assign reg_file_o.dst_addr = dst_q;
  // KEY0 holds the most significant word
  assign reg_file_o.key      = {key_q[0], key_q[1], key_q[2], key_q[3]};

endmodule

// ==== hw/aes_fsm.sv ====
`timescale 1ns/1ps

module aes_fsm import aes_pkg::*; (
  input  logic            clk,
  input  logic            reset_n,
  output ctrl_streamer_t  streamer_ctrl_o,
  input  flags_streamer_t streamer_flags_i,
  output ctrl_engine_t    ctrl_engine_o,
  input  flags_engine_t   flags_engine_i,
  output ctrl_slave_t     slave_ctrl_o,
  input  flags_slave_t    slave_flags_i
);

  aes_state_t current_state;
  aes_state_t next_state;

  always_ff @(posedge clk or negedge reset_n) begin : fsm_seq
    if (!reset_n) begin
      current_state <= AES_IDLE;
    end else begin
      current_state <= next_state;
    end
  end

  always_comb begin : fsm_comb_next_state
    next_state = current_state;
    case (current_state)
      AES_IDLE: begin
        if (slave_flags_i.start) begin
          next_state = AES_STARTING;
        end
      end
      AES_STARTING: begin
        if (streamer_flags_i.src_ready && streamer_flags_i.sink_ready) begin
          next_state = AES_LOADING;
        end
      end
      AES_LOADING: begin
        if (streamer_flags_i.load_done) begin
          next_state = AES_WORKING;
        end
      end
      AES_WORKING: begin
        if (flags_engine_i.done) begin
          next_state = AES_STORING;
        end
      end
      AES_STORING: begin
        if (streamer_flags_i.store_done) begin
          next_state = AES_FINISHED;
        end
      end
      AES_FINISHED: begin
        next_state = AES_IDLE;
      end
      default: begin
        next_state = AES_IDLE;
      end
    endcase
  end

  // Outputs decoded per state, strobes only on the transition
  always_comb begin : fsm_comb_out
    ctrl_engine_o   = '0;
    streamer_ctrl_o = '0;
    slave_ctrl_o    = '0;
    case (current_state)
      AES_IDLE: begin
        ctrl_engine_o.clear = 1'b1;
      end
      AES_STARTING: begin
        if (streamer_flags_i.src_ready && streamer_flags_i.sink_ready) begin
          streamer_ctrl_o.load_start = 1'b1;
        end
      end
      AES_LOADING: begin
        if (streamer_flags_i.load_done) begin
          ctrl_engine_o.start  = 1'b1;
          ctrl_engine_o.enable = 1'b1;
        end
      end
      AES_WORKING: begin
        ctrl_engine_o.enable = 1'b1;
        // Grab the result as soon as the engine finishes
        if (flags_engine_i.done) begin
          streamer_ctrl_o.capture     = 1'b1;
          streamer_ctrl_o.store_start = 1'b1;
        end
      end
      AES_FINISHED: begin
        slave_ctrl_o.done = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== hw/aes_streamer.sv ====
`timescale 1ns/1ps

module aes_streamer import aes_pkg::*; #(
  parameter int ADDR_WIDTH = 16
) (
  input  logic            clk,
  input  logic            reset_n,
  input  ctrl_streamer_t  streamer_ctrl_i,
  output flags_streamer_t streamer_flags_o,
  input  ctrl_regfile_t   reg_file_i,
  aes_mem_if.streamer     mem,
  output aes_block_t      plaintext_o,
  input  aes_block_t      ciphertext_i
);

  typedef enum logic [1:0] {
    STR_IDLE,
    STR_LOAD,
    STR_STORE
  } str_state_t;

  str_state_t            state_q;
  logic [1:0]            word_cnt_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic                  last_word;
  logic                  rd_valid_q;
  logic                  rd_last_q;
  logic                  load_done_q;
  logic                  store_done_q;
  aes_block_t            plain_q;
  aes_block_t            cipher_q;

  assign last_word = (word_cnt_q == 2'd3);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q      <= STR_IDLE;
      word_cnt_q   <= '0;
      addr_q       <= '0;
      rd_valid_q   <= 1'b0;
      rd_last_q    <= 1'b0;
      load_done_q  <= 1'b0;
      store_done_q <= 1'b0;
    end else begin
      // Read data shows up one cycle behind the request
      rd_valid_q   <= (state_q == STR_LOAD);
      rd_last_q    <= (state_q == STR_LOAD) && last_word;
      load_done_q  <= rd_last_q;
      store_done_q <= (state_q == STR_STORE) && last_word;
      case (state_q)
        STR_IDLE: begin
          word_cnt_q <= '0;
          if (streamer_ctrl_i.load_start) begin
            state_q <= STR_LOAD;
            addr_q  <= reg_file_i.src_addr[ADDR_WIDTH-1:0];
          end else if (streamer_ctrl_i.store_start) begin
            state_q <= STR_STORE;
            addr_q  <= reg_file_i.dst_addr[ADDR_WIDTH-1:0];
          end
        end
        STR_LOAD, STR_STORE: begin
          addr_q     <= addr_q + ADDR_WIDTH'(1);
          word_cnt_q <= word_cnt_q + 2'd1;
          if (last_word) begin
            state_q <= STR_IDLE;
          end
        end
        default: begin
          state_q <= STR_IDLE;
        end
      endcase
    end
  end

  // First word ends up in the top of the block
  always_ff @(posedge clk) begin
    if (rd_valid_q) begin
      plain_q <= {plain_q[95:0], mem.rdata};
    end
    if (streamer_ctrl_i.capture) begin
      cipher_q <= ciphertext_i;
    end else if (state_q == STR_STORE) begin
      cipher_q <= {cipher_q[95:0], 32'h0};
    end
  end

  assign mem.req   = (state_q != STR_IDLE);
  assign mem.we    = (state_q == STR_STORE);
  assign mem.addr  = addr_q;
  assign mem.wdata = cipher_q[127:96];

  assign plaintext_o = plain_q;

  assign streamer_flags_o.src_ready  = (state_q != STR_LOAD) && !rd_valid_q;
  assign streamer_flags_o.sink_ready = (state_q != STR_STORE);
  assign streamer_flags_o.load_done  = load_done_q;
  assign streamer_flags_o.store_done = store_done_q;

endmodule

// ==== hw/aes_top.sv ====
`timescale 1ns/1ps

module aes_top import aes_pkg::*; #(
  parameter int ADDR_WIDTH = 16
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  cfg_we_i,
  input  logic [2:0]            cfg_addr_i,
  input  logic [31:0]           cfg_wdata_i,
  output logic [31:0]           cfg_rdata_o,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output logic [ADDR_WIDTH-1:0] mem_addr_o,
  output logic [31:0]           mem_wdata_o,
  input  logic [31:0]           mem_rdata_i,
  output logic                  evt_done_o
);

  ctrl_streamer_t  streamer_ctrl;
  flags_streamer_t streamer_flags;
  ctrl_engine_t    engine_ctrl;
  flags_engine_t   engine_flags;
  ctrl_slave_t     slave_ctrl;
  flags_slave_t    slave_flags;
  ctrl_regfile_t   reg_file;
  aes_block_t      plaintext;
  aes_block_t      ciphertext;

  aes_mem_if #(.ADDR_WIDTH(ADDR_WIDTH)) mem_if ();

  aes_regfile aes_regfile_inst (
    .clk           (clk),
    .reset_n       (reset_n),
    .cfg_we_i      (cfg_we_i),
    .cfg_addr_i    (cfg_addr_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .cfg_rdata_o   (cfg_rdata_o),
    .slave_ctrl_i  (slave_ctrl),
    .slave_flags_o (slave_flags),
    .reg_file_o    (reg_file)
  );

  aes_fsm aes_fsm_inst (
    .clk              (clk),
    .reset_n          (reset_n),
    .streamer_ctrl_o  (streamer_ctrl),
    .streamer_flags_i (streamer_flags),
    .ctrl_engine_o    (engine_ctrl),
    .flags_engine_i   (engine_flags),
    .slave_ctrl_o     (slave_ctrl),
    .slave_flags_i    (slave_flags)
  );

  aes_streamer #(.ADDR_WIDTH(ADDR_WIDTH)) aes_streamer_inst (
    .clk              (clk),
    .reset_n          (reset_n),
    .streamer_ctrl_i  (streamer_ctrl),
    .streamer_flags_o (streamer_flags),
    .reg_file_i       (reg_file),
    .mem              (mem_if.streamer),
    .plaintext_o      (plaintext),
    .ciphertext_i     (ciphertext)
  );

  aes_engine aes_engine_inst (
    .clk            (clk),
    .reset_n        (reset_n),
    .ctrl_engine_i  (engine_ctrl),
    .flags_engine_o (engine_flags),
    .key_i          (reg_file.key),
    .plaintext_i    (plaintext),
    .ciphertext_o   (ciphertext)
  );

  // Memory interface out to plain ports
  assign mem_req_o    = mem_if.req;
  assign mem_we_o     = mem_if.we;
  assign mem_addr_o   = mem_if.addr;
  assign mem_wdata_o  = mem_if.wdata;
  assign mem_if.rdata = mem_rdata_i;

  assign evt_done_o = slave_ctrl.done;

endmodule

// ==== dv/aes_tb.sv ====
`timescale 1ns/1ps

module aes_tb import aes_pkg::*; ();

  localparam int ADDR_WIDTH      = 16;
  localparam int MEM_WORDS       = 1 << ADDR_WIDTH;
  localparam int RESET_CYCLES    = 10;
  localparam int JOB_CYCLES      = 100;
  localparam int NUM_JOBS        = 5;
  localparam int QUIET_CYCLES    = 60;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_JOBS * JOB_CYCLES + QUIET_CYCLES;

  // FIPS-197 appendix C.1 vectors and the all-zero vector
  localparam aes_block_t FIPS_KEY    = 128'h000102030405060708090a0b0c0d0e0f;
  localparam aes_block_t FIPS_PLAIN  = 128'h00112233445566778899aabbccddeeff;
  localparam aes_block_t FIPS_CIPHER = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam aes_block_t ZERO_CIPHER = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

  logic                  clk;
  logic                  reset_n;
  logic                  cfg_we_i;
  logic [2:0]            cfg_addr_i;
  logic [31:0]           cfg_wdata_i;
  logic [31:0]           cfg_rdata_o;
  logic                  mem_req_o;
  logic                  mem_we_o;
  logic [ADDR_WIDTH-1:0] mem_addr_o;
  logic [31:0]           mem_wdata_o;
  logic [31:0]           mem_rdata_i;
  logic                  evt_done_o;

  logic [31:0] mem  [MEM_WORDS];
  logic [31:0] snap [MEM_WORDS];
  logic [31:0] rd_word;
  logic [31:0] mon_src;
  logic [31:0] mon_dst;
  logic        monitor_on;
  integer      seed = 32'heb4794d8;
  int          value_errors;
  int          other_errors;
  int          done_count = 0;
  int          rd_count;
  int          rd_outside;
  int          wr_count;
  int          wr_outside;

  aes_top #(.ADDR_WIDTH(ADDR_WIDTH)) aes_top_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_rdata_i (mem_rdata_i),
    .evt_done_o  (evt_done_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Memory model with one-cycle read latency and a port monitor
  always @(posedge clk) begin
    if (mem_req_o && mem_we_o) begin
      mem[mem_addr_o] <= mem_wdata_o;
    end
    if (monitor_on && mem_req_o) begin
      if (mem_we_o) begin
        wr_count++;
        if ((32'(mem_addr_o) - mon_dst) > 32'd3) wr_outside++;
      end else begin
        rd_count++;
        if ((32'(mem_addr_o) - mon_src) > 32'd3) rd_outside++;
      end
    end
    if (evt_done_o) begin
      done_count++;
    end
    if (mem_req_o && !mem_we_o) begin
      rd_word = mem[mem_addr_o];
      #1 mem_rdata_i = rd_word;
    end
  end

  task automatic report_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("** Error [%s]: expected %08h, actual %08h", test, expected, actual);
    value_errors++;
  endtask

  task automatic report_failure(input string test, input string what);
    $display("** Failure [%s]: %s", test, what);
    other_errors++;
  endtask

  // Host accesses start and end 1 ns after a rising edge
  task automatic write_reg(input aes_reg_t addr, input logic [31:0] data);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(posedge clk);
    #1;
    cfg_we_i = 1'b0;
  endtask

  task automatic read_reg(input aes_reg_t addr, output logic [31:0] data);
    cfg_addr_i = addr;
    #10;
    data = cfg_rdata_o;
    @(posedge clk);
    #1;
  endtask

  task automatic store_block(input logic [ADDR_WIDTH-1:0] addr, input aes_block_t block);
    for (int i = 0; i < 4; i++) begin
      mem[addr + ADDR_WIDTH'(i)] = block[127-32*i -: 32];
    end
  endtask

  task automatic setup_job(input logic [ADDR_WIDTH-1:0] src, input logic [ADDR_WIDTH-1:0] dst,
                           input aes_block_t key);
    write_reg(REG_SRC, 32'(src));
    write_reg(REG_DST, 32'(dst));
    write_reg(REG_KEY0, key[127:96]);
    write_reg(REG_KEY1, key[95:64]);
    write_reg(REG_KEY2, key[63:32]);
    write_reg(REG_KEY3, key[31:0]);
  endtask

  task automatic wait_done(input string test, input int target);
    int cycles;
    cycles = 0;
    while (done_count < target && cycles < JOB_CYCLES) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (done_count < target) begin
      report_failure(test, "the DUT gave no done pulse within the job cycle limit");
    end
  endtask

  task automatic run_job(input string test);
    int target;
    target = done_count + 1;
    write_reg(REG_TRIGGER, 32'h1);
    wait_done(test, target);
  endtask

  task automatic check_block(input string test, input logic [ADDR_WIDTH-1:0] addr,
                             input aes_block_t expected);
    for (int i = 0; i < 4; i++) begin
      if (mem[addr + ADDR_WIDTH'(i)] !== expected[127-32*i -: 32]) begin
        report_mismatch(test, expected[127-32*i -: 32], mem[addr + ADDR_WIDTH'(i)]);
      end
    end
  endtask

  task automatic reset_and_readback();
    logic [31:0] rd;
    logic [31:0] wr [8];
    read_reg(REG_STATUS, rd);
    if (rd !== 32'h0) report_mismatch("reset_regs", 32'h0, rd);
    // Offsets 2 to 7 are SRC, DST and the key words
    for (int i = 2; i < 8; i++) begin
      wr[i] = $random(seed);
      write_reg(aes_reg_t'(i), wr[i]);
    end
    for (int i = 2; i < 8; i++) begin
      read_reg(aes_reg_t'(i), rd);
      if (rd !== wr[i]) report_mismatch("reset_regs", wr[i], rd);
    end
  endtask

  task automatic fips_known_answer();
    store_block(16'h0100, FIPS_PLAIN);
    setup_job(16'h0100, 16'h0200, FIPS_KEY);
    run_job("kat_fips");
    check_block("kat_fips", 16'h0200, FIPS_CIPHER);
  endtask

  task automatic zero_known_answer();
    store_block(16'h1000, '0);
    setup_job(16'h1000, 16'h2000, '0);
    run_job("kat_zero");
    check_block("kat_zero", 16'h2000, ZERO_CIPHER);
  endtask

  task automatic memory_discipline();
    logic [ADDR_WIDTH-1:0] src;
    logic [ADDR_WIDTH-1:0] dst;
    aes_block_t            key;
    int                    changed;
    src = 16'h3000;
    dst = 16'h3010;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = $random(seed);
    end
    key = {$random(seed), $random(seed), $random(seed), $random(seed)};
    setup_job(src, dst, key);
    for (int i = 0; i < MEM_WORDS; i++) begin
      snap[i] = mem[i];
    end
    mon_src    = 32'(src);
    mon_dst    = 32'(dst);
    rd_count   = 0;
    rd_outside = 0;
    wr_count   = 0;
    wr_outside = 0;
    monitor_on = 1'b1;
    run_job("mem_discipline");
    monitor_on = 1'b0;
    if (rd_count != 4) report_mismatch("mem_discipline", 32'd4, 32'(rd_count));
    if (rd_outside != 0) report_mismatch("mem_discipline", 32'd0, 32'(rd_outside));
    if (wr_count != 4) report_mismatch("mem_discipline", 32'd4, 32'(wr_count));
    if (wr_outside != 0) report_mismatch("mem_discipline", 32'd0, 32'(wr_outside));
    changed = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      if ((i < int'(dst) || i > int'(dst) + 3) && mem[i] !== snap[i]) changed++;
    end
    if (changed != 0) report_mismatch("mem_discipline", 32'd0, 32'(changed));
  endtask

  task automatic busy_trigger();
    logic [31:0] status;
    int          target;
    int          cycles;
    store_block(16'h4000, FIPS_PLAIN);
    setup_job(16'h4000, 16'h4100, FIPS_KEY);
    target = done_count + 1;
    write_reg(REG_TRIGGER, 32'h1);
    read_reg(REG_STATUS, status);
    if (status !== 32'h1) report_mismatch("busy", 32'h1, status);
    // Second trigger lands in the done cycle, the last one with busy set
    cycles = 0;
    while (!evt_done_o && cycles < JOB_CYCLES) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!evt_done_o) begin
      report_failure("busy", "the DUT raised no done pulse before the second trigger");
    end
    write_reg(REG_TRIGGER, 32'h1);
    wait_done("busy", target);
    read_reg(REG_STATUS, status);
    if (status !== 32'h0) report_mismatch("busy", 32'h0, status);
    repeat (QUIET_CYCLES) @(posedge clk);
    #1;
    if (done_count != target) report_mismatch("busy", 32'(target), 32'(done_count));
    check_block("busy", 16'h4100, FIPS_CIPHER);
  endtask

  task automatic in_place_job();
    store_block(16'h5000, FIPS_PLAIN);
    setup_job(16'h5000, 16'h5000, FIPS_KEY);
    run_job("in_place");
    check_block("in_place", 16'h5000, FIPS_CIPHER);
  endtask

  initial begin
    reset_n      = 1'b0;
    cfg_we_i     = 1'b0;
    cfg_addr_i   = '0;
    cfg_wdata_i  = '0;
    mem_rdata_i  = '0;
    monitor_on   = 1'b0;
    value_errors = 0;
    other_errors = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {~i[15:0], i[15:0]};
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_n = 1'b1;
    reset_and_readback();
    fips_known_answer();
    zero_known_answer();
    memory_discipline();
    busy_trigger();
    in_place_job();
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Budget covers reset, every job and the quiet window of the busy test
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== aes_top.f ====
common/aes_pkg.sv
common/aes_mem_if.sv
aes_engine/aes_sbox.sv
aes_engine/aes_engine.sv
hw/aes_regfile.sv
hw/aes_fsm.sv
hw/aes_streamer.sv
hw/aes_top.sv
dv/aes_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the AES accelerator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
  --top-module aes_tb -f aes_top.f -o aes_tb_sim

./obj_dir/aes_tb_sim | tee sim.log

if grep -qx "Verification passed" sim.log; then
  exit 0
else
  echo "Testbench did not report success, see sim.log"
  exit 1
fi
